// ==== hdl/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define REG_NUM  32
`define RESET_PC 32'h0000_0000

// primary opcode field, instr[31:26]
`define OP_SPECIAL 6'h00
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// funct field under OP_SPECIAL
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

`endif

// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

typedef logic [31:0] uint32_t;
typedef logic [4:0]  reg_addr_t;

// ALU operations picked by decode
typedef enum logic [2:0] {
	ALU_ADD,
	ALU_SUB,
	ALU_AND,
	ALU_OR,
	ALU_XOR,
	ALU_SLT,
	ALU_LUI
} alu_op_t;

// data bus access carried down to MEM
typedef enum logic [1:0] {
	MEM_NONE,
	MEM_LOAD,
	MEM_STORE
} mem_op_t;

endpackage

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module regfile import cpu_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  reg_addr_t raddr_a,
	input  reg_addr_t raddr_b,
	output uint32_t   rdata_a,
	output uint32_t   rdata_b,
	input  logic      we,
	input  reg_addr_t waddr,
	input  uint32_t   wdata
);

uint32_t regs [`REG_NUM];
logic    wr_en;

// $zero stays hardwired
assign wr_en = we && (waddr != '0);

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < `REG_NUM; i++) begin
			regs[i] <= '0;
		end
	end else if (wr_en) begin
		regs[waddr] <= wdata;
	end
end

// write-first bypass
assign rdata_a = (wr_en && waddr == raddr_a) ? wdata : regs[raddr_a];
assign rdata_b = (wr_en && waddr == raddr_b) ? wdata : regs[raddr_b];

a_zero_reads_zero: assert property (@(posedge clk) disable iff (rst)
	((raddr_a != '0) || (rdata_a == '0)) && ((raddr_b != '0) || (rdata_b == '0)));

endmodule

// ==== hdl/instr_fetch.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instr_fetch import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    stall,
	input  logic    redirect,
	input  uint32_t redirect_pc,
	output logic    ibus_req,
	output uint32_t ibus_addr,
	input  logic    ibus_ack,
	input  uint32_t ibus_rdata,
	output logic    fetch_valid,
	output uint32_t fetch_instr,
	output uint32_t fetch_pc
);

uint32_t pc;
logic    drop;
logic    slot_free;
logic    ack_done;
logic    take_word;

// skid slot empty, or emptied on this edge
assign slot_free = !fetch_valid || !stall;
// a held word waits with req high until it has somewhere to go
assign ack_done  = ibus_req && ibus_ack && (drop || redirect || slot_free);
assign take_word = ack_done && !drop && !redirect;

always_ff @(posedge clk) begin
	if (rst) begin
		pc       <= `RESET_PC;
		ibus_req <= 1'b0;
		drop     <= 1'b0;
	end else begin
		if (ack_done) begin
			ibus_req <= 1'b0;
			drop     <= 1'b0;
		end else if (ibus_req && redirect) begin
			drop <= 1'b1;
		end else if (!ibus_req && !ibus_ack && !redirect) begin
			ibus_req <= 1'b1;
			pc       <= pc + 32'd4;
		end
		if (redirect) begin
			pc <= redirect_pc;
		end
	end
end

// address follows pc only while the bus is quiet
always_ff @(posedge clk) begin
	if (!ibus_req && !ibus_ack) begin
		ibus_addr <= pc;
	end
end

always_ff @(posedge clk) begin
	if (rst || redirect) begin
		fetch_valid <= 1'b0;
	end else if (take_word) begin
		fetch_valid <= 1'b1;
	end else if (!stall) begin
		fetch_valid <= 1'b0;
	end
	if (take_word) begin
		fetch_instr <= ibus_rdata;
		fetch_pc    <= ibus_addr;
	end
end

a_ibus_addr_stable: assert property (@(posedge clk) disable iff (rst)
	(ibus_req && !ibus_ack) |=> $stable(ibus_addr));

endmodule

// ==== hdl/decode_and_issue.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_and_issue import cpu_pkg::*; (
	input  logic      id_valid,
	input  uint32_t   id_instr,
	output reg_addr_t rf_raddr_a,
	output reg_addr_t rf_raddr_b,
	input  uint32_t   rf_rdata_a,
	input  uint32_t   rf_rdata_b,
	input  mem_op_t   ex_mem_op,
	input  reg_addr_t ex_rd,
	output logic      dec_valid,
	output alu_op_t   dec_alu_op,
	output mem_op_t   dec_mem_op,
	output logic      dec_is_branch,
	output logic      dec_branch_ne,
	output logic      dec_use_imm,
	output uint32_t   dec_imm,
	output reg_addr_t dec_rs,
	output reg_addr_t dec_rt,
	output reg_addr_t dec_rd,
	output uint32_t   dec_opa,
	output uint32_t   dec_opb,
	output logic      hazard_stall
);

logic [5:0]  opcode;
logic [5:0]  funct;
logic [15:0] imm16;
logic        reads_rt;

assign opcode     = id_instr[31:26];
assign funct      = id_instr[5:0];
assign imm16      = id_instr[15:0];
assign dec_rs     = id_instr[25:21];
assign dec_rt     = id_instr[20:16];
assign rf_raddr_a = dec_rs;
assign rf_raddr_b = dec_rt;
assign dec_opa    = rf_rdata_a;
assign dec_opb    = rf_rdata_b;
assign dec_valid  = id_valid;

always_comb begin
	dec_alu_op    = ALU_ADD;
	dec_mem_op    = MEM_NONE;
	dec_is_branch = 1'b0;
	dec_branch_ne = 1'b0;
	dec_use_imm   = 1'b0;
	dec_imm       = {{16{imm16[15]}}, imm16};
	dec_rd        = '0;
	reads_rt      = 1'b0;
	case (opcode)
		`OP_SPECIAL: begin
			reads_rt = 1'b1;
			dec_rd   = id_instr[15:11];
			case (funct)
				`FN_ADDU: dec_alu_op = ALU_ADD;
				`FN_SUBU: dec_alu_op = ALU_SUB;
				`FN_AND:  dec_alu_op = ALU_AND;
				`FN_OR:   dec_alu_op = ALU_OR;
				`FN_XOR:  dec_alu_op = ALU_XOR;
				`FN_SLT:  dec_alu_op = ALU_SLT;
				default:  dec_rd = '0;
			endcase
		end
		`OP_ADDIU: begin
			dec_use_imm = 1'b1;
			dec_rd      = dec_rt;
		end
		`OP_ORI: begin
			dec_alu_op  = ALU_OR;
			dec_use_imm = 1'b1;
			dec_imm     = {16'h0000, imm16};
			dec_rd      = dec_rt;
		end
		`OP_LUI: begin
			dec_alu_op  = ALU_LUI;
			dec_use_imm = 1'b1;
			dec_imm     = {imm16, 16'h0000};
			dec_rd      = dec_rt;
		end
		`OP_LW: begin
			dec_use_imm = 1'b1;
			dec_mem_op  = MEM_LOAD;
			dec_rd      = dec_rt;
		end
		`OP_SW: begin
			dec_use_imm = 1'b1;
			dec_mem_op  = MEM_STORE;
			reads_rt    = 1'b1;
		end
		`OP_BEQ, `OP_BNE: begin
			dec_is_branch = 1'b1;
			dec_branch_ne = (opcode == `OP_BNE);
			reads_rt      = 1'b1;
		end
		default: ;
	endcase
	// bubbles write nothing and touch no bus
	if (!id_valid) begin
		dec_rd        = '0;
		dec_mem_op    = MEM_NONE;
		dec_is_branch = 1'b0;
	end
end

// load in EX whose result the instruction in ID needs
assign hazard_stall = id_valid && (ex_mem_op == MEM_LOAD) && (ex_rd != '0)
	&& ((ex_rd == dec_rs) || (reads_rt && (ex_rd == dec_rt)));

endmodule

// ==== hdl/instr_exec.sv ====
`timescale 1ns/1ps

module instr_exec import cpu_pkg::*; (
	input  alu_op_t ex_alu_op,
	input  logic    ex_use_imm,
	input  uint32_t ex_imm,
	input  uint32_t ex_opa,
	input  uint32_t ex_opb,
	input  uint32_t ex_pc,
	input  logic    ex_is_branch,
	input  logic    ex_branch_ne,
	output uint32_t alu_result,
	output logic    branch_taken,
	output uint32_t branch_target
);

uint32_t src_b;
logic    equal;

assign src_b = ex_use_imm ? ex_imm : ex_opb;

always_comb begin
	case (ex_alu_op)
		ALU_ADD: alu_result = ex_opa + src_b;
		ALU_SUB: alu_result = ex_opa - src_b;
		ALU_AND: alu_result = ex_opa & src_b;
		ALU_OR:  alu_result = ex_opa | src_b;
		ALU_XOR: alu_result = ex_opa ^ src_b;
		ALU_SLT: alu_result = {31'b0, $signed(ex_opa) < $signed(src_b)};
		// immediate already sits in the upper half
		ALU_LUI: alu_result = src_b;
		default: alu_result = '0;
	endcase
end

// branches compare the two registers, never the immediate
assign equal         = (ex_opa == ex_opb);
assign branch_taken  = ex_is_branch && (equal != ex_branch_ne);
assign branch_target = ex_pc + 32'd4 + {ex_imm[29:0], 2'b00};

endmodule

// ==== hdl/mem_access.sv ====
`timescale 1ns/1ps

module mem_access import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  mem_op_t mem_op,
	input  uint32_t mem_addr,
	input  uint32_t mem_wdata,
	output logic    dbus_req,
	output logic    dbus_we,
	output uint32_t dbus_addr,
	output uint32_t dbus_wdata,
	input  logic    dbus_ack,
	input  uint32_t dbus_rdata,
	output uint32_t load_data,
	output logic    mem_busy
);

typedef enum logic [1:0] {
	S_IDLE,
	S_WAIT_ACK,
	S_WAIT_REL
} state_t;

state_t state;
logic   done;

// done marks the single cycle the finished access may leave MEM
assign mem_busy = (mem_op != MEM_NONE) && !done;

always_ff @(posedge clk) begin
	if (rst) begin
		state    <= S_IDLE;
		dbus_req <= 1'b0;
		dbus_we  <= 1'b0;
		done     <= 1'b0;
	end else begin
		done <= 1'b0;
		case (state)
			S_IDLE: begin
				if (mem_op != MEM_NONE) begin
					state    <= S_WAIT_ACK;
					dbus_req <= 1'b1;
					dbus_we  <= (mem_op == MEM_STORE);
				end
			end
			S_WAIT_ACK: begin
				if (dbus_ack) begin
					state    <= S_WAIT_REL;
					dbus_req <= 1'b0;
					dbus_we  <= 1'b0;
					done     <= 1'b1;
				end
			end
			S_WAIT_REL: begin
				// no new request until the slave lets go of ack
				if (!dbus_ack) begin
					state <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (state == S_IDLE) begin
		dbus_addr  <= mem_addr;
		dbus_wdata <= mem_wdata;
	end
	if (state == S_WAIT_ACK && dbus_ack) begin
		load_data <= dbus_rdata;
	end
end

a_req_held_to_ack: assert property (@(posedge clk) disable iff (rst)
	(dbus_req && !dbus_ack) |=> dbus_req);

endmodule

// ==== hdl/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	output logic    ibus_req,
	output uint32_t ibus_addr,
	input  logic    ibus_ack,
	input  uint32_t ibus_rdata,
	output logic    dbus_req,
	output logic    dbus_we,
	output uint32_t dbus_addr,
	output uint32_t dbus_wdata,
	input  logic    dbus_ack,
	input  uint32_t dbus_rdata
);

logic      fetch_valid;
uint32_t   fetch_instr;
uint32_t   fetch_pc;
logic      id_valid;
uint32_t   id_instr;
uint32_t   id_pc;

reg_addr_t rf_raddr_a;
reg_addr_t rf_raddr_b;
uint32_t   rf_rdata_a;
uint32_t   rf_rdata_b;

logic      dec_valid;
alu_op_t   dec_alu_op;
mem_op_t   dec_mem_op;
logic      dec_is_branch;
logic      dec_branch_ne;
logic      dec_use_imm;
uint32_t   dec_imm;
reg_addr_t dec_rs;
reg_addr_t dec_rt;
reg_addr_t dec_rd;
uint32_t   dec_opa;
uint32_t   dec_opb;
logic      hazard_stall;

logic      ex_valid;
alu_op_t   ex_alu_op;
mem_op_t   ex_mem_op;
logic      ex_is_branch;
logic      ex_branch_ne;
logic      ex_use_imm;
uint32_t   ex_imm;
reg_addr_t ex_rs;
reg_addr_t ex_rt;
reg_addr_t ex_rd;
uint32_t   ex_opa;
uint32_t   ex_opb;
uint32_t   ex_pc;
uint32_t   fwd_a;
uint32_t   fwd_b;
uint32_t   alu_result;
logic      branch_taken;
uint32_t   branch_target;

logic      mm_valid;
mem_op_t   mm_mem_op;
reg_addr_t mm_rd;
uint32_t   mm_result;
uint32_t   mm_wdata;
uint32_t   load_data;
logic      mem_busy;

logic      wb_valid;
logic      wb_is_load;
reg_addr_t wb_rd;
uint32_t   wb_result;
uint32_t   wb_wdata;

logic      branch_go;
logic      stall_front;

// a branch held in EX by MEM redirects once it can move on
assign branch_go   = branch_taken && !mem_busy;
assign stall_front = mem_busy || hazard_stall;

instr_fetch instr_fetch_inst (
	.clk,
	.rst,
	.stall       ( stall_front   ),
	.redirect    ( branch_go     ),
	.redirect_pc ( branch_target ),
	.ibus_req,
	.ibus_addr,
	.ibus_ack,
	.ibus_rdata,
	.fetch_valid,
	.fetch_instr,
	.fetch_pc
);

// IF/ID
always_ff @(posedge clk) begin
	if (rst || branch_go) begin
		id_valid <= 1'b0;
	end else if (!stall_front) begin
		id_valid <= fetch_valid;
	end
	if (!stall_front) begin
		id_instr <= fetch_instr;
		id_pc    <= fetch_pc;
	end
end

regfile regfile_inst (
	.clk,
	.rst,
	.raddr_a ( rf_raddr_a ),
	.raddr_b ( rf_raddr_b ),
	.rdata_a ( rf_rdata_a ),
	.rdata_b ( rf_rdata_b ),
	.we      ( wb_valid   ),
	.waddr   ( wb_rd      ),
	.wdata   ( wb_wdata   )
);

decode_and_issue decode_issue_inst (.*);

// ID/EX
always_ff @(posedge clk) begin
	if (rst || branch_go || (hazard_stall && !mem_busy)) begin
		ex_valid     <= 1'b0;
		ex_mem_op    <= MEM_NONE;
		ex_is_branch <= 1'b0;
		ex_rd        <= '0;
	end else if (!mem_busy) begin
		ex_valid     <= dec_valid;
		ex_mem_op    <= dec_mem_op;
		ex_is_branch <= dec_is_branch;
		ex_rd        <= dec_rd;
	end
	if (mem_busy) begin
		// MEM/WB drains to bubbles, so keep forwarded operands
		ex_opa <= fwd_a;
		ex_opb <= fwd_b;
	end else begin
		ex_alu_op    <= dec_alu_op;
		ex_branch_ne <= dec_branch_ne;
		ex_use_imm   <= dec_use_imm;
		ex_imm       <= dec_imm;
		ex_rs        <= dec_rs;
		ex_rt        <= dec_rt;
		ex_opa       <= dec_opa;
		ex_opb       <= dec_opb;
		ex_pc        <= id_pc;
	end
end

// forwarding, youngest producer first
assign fwd_a = (mm_valid && mm_rd != '0 && mm_mem_op != MEM_LOAD && mm_rd == ex_rs) ?
	mm_result : (wb_valid && wb_rd != '0 && wb_rd == ex_rs) ? wb_wdata : ex_opa;
assign fwd_b = (mm_valid && mm_rd != '0 && mm_mem_op != MEM_LOAD && mm_rd == ex_rt) ?
	mm_result : (wb_valid && wb_rd != '0 && wb_rd == ex_rt) ? wb_wdata : ex_opb;

instr_exec instr_exec_inst (
	.ex_alu_op,
	.ex_use_imm,
	.ex_imm,
	.ex_opa ( fwd_a ),
	.ex_opb ( fwd_b ),
	.ex_pc,
	.ex_is_branch,
	.ex_branch_ne,
	.alu_result,
	.branch_taken,
	.branch_target
);

// EX/MEM
always_ff @(posedge clk) begin
	if (rst) begin
		mm_valid  <= 1'b0;
		mm_mem_op <= MEM_NONE;
		mm_rd     <= '0;
	end else if (!mem_busy) begin
		mm_valid  <= ex_valid;
		mm_mem_op <= ex_mem_op;
		mm_rd     <= ex_rd;
	end
	if (!mem_busy) begin
		mm_result <= alu_result;
		mm_wdata  <= fwd_b;
	end
end

mem_access mem_access_inst (
	.clk,
	.rst,
	.mem_op    ( mm_mem_op ),
	.mem_addr  ( mm_result ),
	.mem_wdata ( mm_wdata  ),
	.dbus_req,
	.dbus_we,
	.dbus_addr,
	.dbus_wdata,
	.dbus_ack,
	.dbus_rdata,
	.load_data,
	.mem_busy
);

// MEM/WB
always_ff @(posedge clk) begin
	if (rst || mem_busy) begin
		wb_valid <= 1'b0;
		wb_rd    <= '0;
	end else begin
		wb_valid <= mm_valid;
		wb_rd    <= mm_rd;
	end
	wb_result  <= mm_result;
	wb_is_load <= (mm_mem_op == MEM_LOAD);
end

// load data holds until the next access completes
assign wb_wdata = wb_is_load ? load_data : wb_result;

endmodule

// ==== dv/core_checker.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module core_checker import cpu_pkg::*; #(
	parameter int PROG_WORDS = 64
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    ibus_req,
	input  logic    dbus_req,
	input  logic    dbus_we,
	input  logic    dbus_ack,
	input  uint32_t dbus_addr,
	input  uint32_t dbus_wdata,
	input  uint32_t prog [PROG_WORDS],
	output logic    checks_done,
	output int      error_count,
	output int      store_count,
	output int      ref_instr_count
);

localparam uint32_t HALT_ADDR = 32'h0000_fffc;

uint32_t exp_addr [$];
uint32_t exp_data [$];
uint32_t model_mem [16384];

// architectural model, one instruction at a time, no delay slots
function automatic int run_reference();
	uint32_t    regs [`REG_NUM];
	uint32_t    pc;
	uint32_t    pc_next;
	uint32_t    ins;
	uint32_t    a;
	uint32_t    b;
	uint32_t    simm;
	uint32_t    result;
	uint32_t    ea;
	reg_addr_t  dest;
	int         count;
	logic       halted;

	foreach (regs[i]) regs[i] = '0;
	foreach (model_mem[i]) model_mem[i] = '0;
	pc     = `RESET_PC;
	count  = 0;
	halted = 1'b0;
	while (!halted && count < 4096) begin
		ins     = prog[(pc >> 2) % PROG_WORDS];
		a       = regs[ins[25:21]];
		b       = regs[ins[20:16]];
		simm    = {{16{ins[15]}}, ins[15:0]};
		pc_next = pc + 32'd4;
		dest    = '0;
		result  = '0;
		case (ins[31:26])
			`OP_SPECIAL: begin
				dest = ins[15:11];
				case (ins[5:0])
					`FN_ADDU: result = a + b;
					`FN_SUBU: result = a - b;
					`FN_AND:  result = a & b;
					`FN_OR:   result = a | b;
					`FN_XOR:  result = a ^ b;
					`FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					default:  dest = '0;
				endcase
			end
			`OP_ADDIU: begin
				dest   = ins[20:16];
				result = a + simm;
			end
			`OP_ORI: begin
				dest   = ins[20:16];
				result = a | {16'h0000, ins[15:0]};
			end
			`OP_LUI: begin
				dest   = ins[20:16];
				result = {ins[15:0], 16'h0000};
			end
			`OP_LW: begin
				ea     = a + simm;
				dest   = ins[20:16];
				result = model_mem[ea[15:2]];
			end
			`OP_SW: begin
				ea = a + simm;
				model_mem[ea[15:2]] = b;
				exp_addr.push_back(ea);
				exp_data.push_back(b);
				halted = (ea == HALT_ADDR);
			end
			`OP_BEQ: if (a == b) pc_next = pc + 32'd4 + (simm << 2);
			`OP_BNE: if (a != b) pc_next = pc + 32'd4 + (simm << 2);
			default: ;
		endcase
		if (dest != '0) begin
			regs[dest] = result;
		end
		pc = pc_next;
		count++;
	end
	return count;
endfunction

task automatic compare_store(input uint32_t addr, input uint32_t data);
	uint32_t want_addr;
	uint32_t want_data;

	store_count++;
	if (exp_addr.size() == 0) begin
		$display("%0t: extra store to %h with data %h beyond the expected stores",
			$time, addr, data);
		error_count++;
	end else begin
		want_addr = exp_addr.pop_front();
		want_data = exp_data.pop_front();
		if (addr !== want_addr) begin
			$display("** Error at %0t: dbus_addr expected %h, got %h", $time, want_addr, addr);
			error_count++;
		end
		if (data !== want_data) begin
			$display("** Error at %0t: dbus_wdata expected %h, got %h", $time, want_data, data);
			error_count++;
		end
	end
	if (addr == HALT_ADDR) begin
		if (exp_addr.size() != 0) begin
			$display("%0t: halt store reached with %0d expected stores missing",
				$time, exp_addr.size());
			error_count++;
		end
		checks_done = 1'b1;
	end
endtask

initial begin
	checks_done     = 1'b0;
	error_count     = 0;
	store_count     = 0;
	ref_instr_count = 0;
	// program image is loaded at time zero by the top
	@(posedge clk);
	ref_instr_count = run_reference();
	if (exp_addr.size() == 0 || exp_addr[$] != HALT_ADDR) begin
		$display("reference model never reached the halt store");
		error_count++;
	end
end

// sampled on the edge where the master sees ack and drops req
always @(posedge clk) begin
	if (rst) begin
		if (ibus_req === 1'b1 || dbus_req === 1'b1) begin
			$display("%0t: bus request raised during reset", $time);
			error_count++;
		end
	end else if (!checks_done && dbus_req && dbus_ack && dbus_we) begin
		compare_store(dbus_addr, dbus_wdata);
	end
end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_top import cpu_pkg::*; ();

localparam int IMEM_WORDS = 64;
localparam int DMEM_WORDS = 16384;

logic    clk = 1'b0;
logic    rst;
logic    ibus_req;
uint32_t ibus_addr;
logic    ibus_ack;
uint32_t ibus_rdata;
logic    dbus_req;
logic    dbus_we;
uint32_t dbus_addr;
uint32_t dbus_wdata;
logic    dbus_ack;
uint32_t dbus_rdata;
logic    checks_done;
int      error_count;
int      store_count;
int      ref_instr_count;
integer  seed;

uint32_t imem [IMEM_WORDS];
uint32_t dmem [DMEM_WORDS];

always #5 clk = ~clk;

cpu_core dut0 (.*);

core_checker #(
	.PROG_WORDS ( IMEM_WORDS )
) chk0 (
	.clk,
	.rst,
	.ibus_req,
	.dbus_req,
	.dbus_we,
	.dbus_ack,
	.dbus_addr,
	.dbus_wdata,
	.prog            ( imem ),
	.checks_done,
	.error_count,
	.store_count,
	.ref_instr_count
);

function automatic uint32_t r_type(input logic [5:0] funct, input reg_addr_t rd,
	input reg_addr_t rs, input reg_addr_t rt);
	return {`OP_SPECIAL, rs, rt, rd, 5'd0, funct};
endfunction

function automatic uint32_t i_type(input logic [5:0] op, input reg_addr_t rt,
	input reg_addr_t rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic int ack_delay();
	return $unsigned($random(seed)) % 4;
endfunction

task automatic load_program();
	foreach (imem[i]) imem[i] = '0;
	imem[0]  = i_type(`OP_LUI, 1, 0, 16'h8000);
	imem[1]  = i_type(`OP_ORI, 1, 1, 16'h1234);
	// sign extends to -5
	imem[2]  = i_type(`OP_ADDIU, 2, 0, 16'hfffb);
	imem[3]  = i_type(`OP_ORI, 3, 0, 16'h8001);
	imem[4]  = i_type(`OP_ADDIU, 4, 0, 16'h0100);
	imem[5]  = r_type(`FN_ADDU, 5, 1, 2);
	imem[6]  = i_type(`OP_SW, 5, 4, 16'h0000);
	imem[7]  = r_type(`FN_SUBU, 6, 3, 2);
	imem[8]  = i_type(`OP_SW, 6, 4, 16'h0004);
	// and, or, xor chained back to back
	imem[9]  = r_type(`FN_AND, 7, 1, 2);
	imem[10] = r_type(`FN_OR, 8, 7, 3);
	imem[11] = r_type(`FN_XOR, 9, 8, 1);
	imem[12] = i_type(`OP_SW, 9, 4, 16'h0008);
	imem[13] = r_type(`FN_SLT, 10, 1, 3);
	imem[14] = r_type(`FN_SLT, 11, 3, 2);
	imem[15] = i_type(`OP_SW, 10, 4, 16'h000c);
	imem[16] = i_type(`OP_SW, 11, 4, 16'h0010);
	// load with immediate use
	imem[17] = i_type(`OP_LW, 13, 4, 16'h0000);
	imem[18] = r_type(`FN_ADDU, 14, 13, 13);
	imem[19] = i_type(`OP_SW, 14, 4, 16'h0014);
	imem[20] = i_type(`OP_LW, 15, 4, 16'h0004);
	imem[21] = i_type(`OP_SW, 15, 4, 16'h0018);
	// wrong-path stores behind taken branches must never reach the bus
	imem[22] = i_type(`OP_BEQ, 1, 1, 16'h0001);
	imem[23] = i_type(`OP_SW, 1, 4, 16'h001c);
	imem[24] = i_type(`OP_BNE, 1, 1, 16'h0002);
	imem[25] = i_type(`OP_BEQ, 2, 1, 16'h0001);
	imem[26] = i_type(`OP_BNE, 6, 5, 16'h0001);
	imem[27] = i_type(`OP_SW, 2, 4, 16'h001c);
	imem[28] = i_type(`OP_LW, 16, 4, 16'h0000);
	imem[29] = i_type(`OP_BEQ, 5, 16, 16'h0001);
	imem[30] = i_type(`OP_SW, 16, 4, 16'h0020);
	imem[31] = i_type(`OP_SW, 2, 4, 16'h0024);
	imem[32] = i_type(`OP_ORI, 17, 0, 16'hfffc);
	imem[33] = i_type(`OP_SW, 14, 17, 16'h0000);
	// spin here after the halt store
	imem[34] = i_type(`OP_BEQ, 0, 0, 16'hffff);
endtask

task automatic fill_data_memory();
	foreach (dmem[i]) dmem[i] = (i * 32'h9e37_79b9) ^ 32'h1f2e_3d4c;
endtask

task automatic report_summary();
	$display("stores checked: %0d, errors: %0d", store_count, error_count);
endtask

initial begin
	seed       = 32'ha2ea;
	rst        = 1'b1;
	ibus_ack   = 1'b0;
	ibus_rdata = '0;
	dbus_ack   = 1'b0;
	dbus_rdata = '0;
	load_program();
	fill_data_memory();
	repeat (16) @(posedge clk);
	@(negedge clk);
	rst = 1'b0;
end

initial begin : ibus_slave
	int delay;
	forever begin
		@(negedge clk);
		if (!rst && ibus_req) begin
			delay = ack_delay();
			repeat (delay) @(negedge clk);
			ibus_rdata = imem[ibus_addr[7:2]];
			ibus_ack   = 1'b1;
			@(negedge clk);
			while (ibus_req) @(negedge clk);
			ibus_ack = 1'b0;
		end
	end
end

initial begin : dbus_slave
	int delay;
	forever begin
		@(negedge clk);
		if (!rst && dbus_req) begin
			delay = ack_delay();
			repeat (delay) @(negedge clk);
			if (dbus_we) begin
				dmem[dbus_addr[15:2]] = dbus_wdata;
			end else begin
				dbus_rdata = dmem[dbus_addr[15:2]];
			end
			dbus_ack = 1'b1;
			@(negedge clk);
			while (dbus_req) @(negedge clk);
			dbus_ack = 1'b0;
		end
	end
end

initial begin : end_of_run
	wait (checks_done === 1'b1);
	report_summary();
	if (error_count == 0) begin
		$display("all tests passed");
	end else begin
		$display("tests failed");
	end
	$finish;
end

initial begin : watchdog
	@(negedge rst);
	repeat (ref_instr_count * 40) @(posedge clk);
	$display("watchdog expired: no halt store within %0d cycles after reset",
		ref_instr_count * 40);
	report_summary();
	$display("tests failed");
	$finish;
end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/regfile.sv
hdl/instr_fetch.sv
hdl/decode_and_issue.sv
hdl/instr_exec.sv
hdl/mem_access.sv
hdl/cpu_core.sv
dv/core_checker.sv
dv/tb_top.sv
